/* vlog.f */
+incdir+tb
src/soc_pkg.sv
src/rst_debounce.sv
src/bus_switch.sv
src/gpio_regs.sv
src/simple_pic.sv
src/soc_top.sv
tb/tb_soc.sv

/* Bender.yml */
package:
  name: soc_fabric

sources:
  - src/soc_pkg.sv
  - src/rst_debounce.sv
  - src/bus_switch.sv
  - src/gpio_regs.sv
  - src/simple_pic.sv
  - src/soc_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_soc.sv

/* tb/tb_ref.svh */
// Testbench reference model
// Address decode, expected read words, LED lane update and interrupt order
`ifndef TB_REF_SVH
`define TB_REF_SVH

localparam int T_GPIO = 0;
localparam int T_DEF  = 1;
localparam int T_MEM  = 2;

// Target selected by a byte address and the I/O flag
function automatic int target_of(input logic tga, input logic [19:0] badr);
  if (!tga) begin
    return T_MEM;
  end
  if ((badr[15:0] & 16'hfffc) == 16'hf100) begin
    return T_GPIO;  // Switch and LED words
  end
  return T_DEF;
endfunction

// Byte-lane write into a 16-bit word
function automatic logic [15:0] lane_merge(input logic [15:0] old, input logic [15:0] wd,
                                           input logic [1:0] sel);
  logic [15:0] res;
  res = old;
  if (sel[0]) begin
    res[7:0] = wd[7:0];
  end
  if (sel[1]) begin
    res[15:8] = wd[15:8];
  end
  return res;
endfunction

function automatic logic [13:0] led_update(input logic [13:0] old, input logic [15:0] wd,
                                           input logic [1:0] sel);
  return 14'(lane_merge({2'b00, old}, wd, sel));  // Upper lane keeps 6 bits
endfunction

function automatic logic [15:0] expect_read(input int tgt, input logic [19:0] badr,
                                            input logic [9:0] sw, input logic [13:0] leds,
                                            input logic [15:0] mem_word);
  case (tgt)
    T_GPIO:  return badr[1] ? {2'b00, leds} : {6'b000000, sw};
    T_DEF:   return 16'hffff;  // Unmapped I/O
    default: return mem_word;
  endcase
endfunction

// Lowest pending line
function automatic logic [2:0] expect_iid(input logic [7:0] pend);
  for (int i = 0; i < 8; i++) begin
    if (pend[i]) begin
      return 3'(i);
    end
  end
  return 3'd0;
endfunction

// Initial memory contents
function automatic logic [15:0] fill_word(input logic [5:0] a);
  return 16'hc35a ^ {a, 4'b1001, ~a};
endfunction

`endif

/* tb/tb_soc.sv */
// SoC bus fabric testbench
// Drives the master port, models external memory and checks GPIO, memory,
// default responder, interrupt acknowledge and reset release
module tb_soc;
  import soc_pkg::*;

  `include "tb_ref.svh"

  localparam int DEB            = 16;
  localparam int TIMEOUT_CYCLES = 4000;

  logic    clk;
  logic    rst_lck;
  wb_req_t m_req;
  wb_rsp_t m_rsp;
  irq_t    irq;
  logic    inta;
  logic    intr;
  sw_t     sw;
  leds_t   leds;
  wb_req_t mem_req;
  wb_rsp_t mem_rsp;
  logic    rst;

  integer     seed = 32'h04871ac0;
  int         cycles = 0;
  data_t      mem [64];      // External memory model
  data_t      exp_mem [64];  // Expected memory contents
  leds_t      exp_leds;
  logic [1:0] mem_lat;
  logic [1:0] mem_wait;

  soc_top #(
    .DEBOUNCE_CYCLES (DEB)
  ) dut (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .m_req_i   (m_req),
    .m_rsp_o   (m_rsp),
    .irq_i     (irq),
    .inta_i    (inta),
    .intr_o    (intr),
    .sw_i      (sw),
    .leds_o    (leds),
    .mem_req_o (mem_req),
    .mem_rsp_i (mem_rsp),
    .rst_o     (rst)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  // Memory model with 0 to 3 wait states before a one-cycle ack
  always @(posedge clk) begin
    mem_rsp.ack <= 1'b0;
    if (mem_req.cyc && mem_req.stb && !mem_rsp.ack) begin
      if (mem_wait == mem_lat) begin
        mem_rsp.ack <= 1'b1;
        mem_rsp.dat <= mem[mem_req.adr[6:1]];
        if (mem_req.we) begin
          mem[mem_req.adr[6:1]] <= lane_merge(mem[mem_req.adr[6:1]], mem_req.dat, mem_req.sel);
        end
        mem_wait <= '0;
        mem_lat  <= 2'($random(seed));
      end else begin
        mem_wait <= mem_wait + 2'd1;
      end
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error %s: got %h, expected %h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // One master access that returns the read data
  task automatic bus_access(input logic tga, input logic [19:0] badr, input logic we,
                            input data_t wdat, input sel_t sel, output data_t rdat);
    wb_req_t req;
    req.adr = badr[19:1];
    req.tga = tga;
    req.dat = wdat;
    req.sel = sel;
    req.we  = we;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    @(posedge clk);
    m_req <= req;
    @(negedge clk);
    check_val("mem_req_o.stb", mem_req.stb, target_of(tga, badr) == T_MEM);
    while (!m_rsp.ack) @(negedge clk);
    rdat = m_rsp.dat;
    @(posedge clk);
    m_req <= '0;
  endtask

  initial begin
    data_t      rd;
    data_t      wd;
    sel_t       sel;
    logic [19:0] badr;
    logic       we;
    irq_t       pend;
    irq_t       pulse;
    logic [2:0] id;
    m_req    = '0;
    mem_rsp  = '0;
    irq      = '0;
    inta     = 1'b0;
    sw       = '0;
    rst_lck  = 1'b0;
    mem_lat  = '0;
    mem_wait = '0;
    exp_leds = '0;
    for (int i = 0; i < 64; i++) begin
      mem[i]     = fill_word(6'(i));
      exp_mem[i] = fill_word(6'(i));
    end
    repeat (5) @(posedge clk);
    rst_lck <= 1'b1;

    // Reset release after the debounce count
    repeat (DEB + 1) begin
      @(negedge clk);
      check_val("rst_o", rst, 1);
    end
    @(negedge clk);
    check_val("rst_o", rst, 0);
    check_val("leds_o", leds, 0);
    check_val("intr_o", intr, 0);
    check_val("m_rsp_o.ack", m_rsp.ack, 0);
    check_val("mem_req_o.cyc", mem_req.cyc, 0);

    // GPIO switches and LEDs
    repeat (8) begin
      @(posedge clk);
      sw <= sw_t'($random(seed));
      bus_access(1'b1, 20'h0f100, 1'b0, '0, 2'b11, rd);
      check_val("m_rsp_o.dat", rd, expect_read(T_GPIO, 20'h0f100, sw, exp_leds, '0));
    end
    repeat (8) begin
      wd  = data_t'($random(seed));
      sel = sel_t'($random(seed));
      bus_access(1'b1, 20'h0f102, 1'b1, wd, sel, rd);
      exp_leds = led_update(exp_leds, wd, sel);
      @(negedge clk);
      check_val("leds_o", leds, exp_leds);
      bus_access(1'b1, 20'h0f102, 1'b0, '0, 2'b11, rd);
      check_val("m_rsp_o.dat", rd, expect_read(T_GPIO, 20'h0f102, sw, exp_leds, '0));
    end

    // Mixed writes and reads across memory space
    repeat (96) begin
      badr = {19'($random(seed)), 1'b0};
      we   = 1'($random(seed));
      wd   = data_t'($random(seed));
      sel  = sel_t'($random(seed));
      bus_access(1'b0, badr, we, wd, sel, rd);
      if (we) begin
        exp_mem[badr[6:1]] = lane_merge(exp_mem[badr[6:1]], wd, sel);
      end else begin
        check_val("m_rsp_o.dat", rd, expect_read(T_MEM, badr, sw, exp_leds, exp_mem[badr[6:1]]));
      end
    end

    // Unmapped I/O
    repeat (16) begin
      badr = 20'($random(seed));
      if (target_of(1'b1, badr) == T_GPIO) begin
        badr[12] = ~badr[12];
      end
      bus_access(1'b1, badr, 1'b0, '0, 2'b11, rd);
      check_val("m_rsp_o.dat", rd, expect_read(T_DEF, badr, sw, exp_leds, '0));
    end

    // Interrupt acknowledge order
    repeat (6) begin
      pend = '0;
      repeat (2) begin
        pulse = irq_t'($random(seed));
        if (pulse == '0) begin
          pulse = 8'h01;
        end
        @(posedge clk);
        irq <= pulse;
        @(posedge clk);
        irq <= '0;
        pend = pend | pulse;
      end
      @(negedge clk);
      while (!intr) @(negedge clk);
      while (pend != '0) begin
        wait_cycles(3);
        id = expect_iid(pend);
        @(posedge clk);
        inta <= 1'b1;
        @(negedge clk);
        check_val("m_rsp_o.dat", m_rsp.dat, 16'h0008 + 16'(id));  // Vector base plus line
        @(posedge clk);
        inta <= 1'b0;
        pend[id] = 1'b0;
      end
      wait_cycles(3);
      @(negedge clk);
      check_val("intr_o", intr, 0);
    end

    wait_cycles(2);
    $display("TEST OK");
    $finish;
  end

endmodule

/* src/soc_top.sv */
// SoC bus fabric top level
// Connects the reset debouncer, bus switch, GPIO block and interrupt
// controller, and returns the vector word during interrupt acknowledge
module soc_top #(
  parameter int DEBOUNCE_CYCLES = 1000
) (
  input  logic             clk,
  input  logic             rst_lck,
  input  soc_pkg::wb_req_t m_req_i,
  output soc_pkg::wb_rsp_t m_rsp_o,
  input  soc_pkg::irq_t    irq_i,
  input  logic             inta_i,
  output logic             intr_o,
  input  soc_pkg::sw_t     sw_i,
  output soc_pkg::leds_t   leds_o,
  output soc_pkg::wb_req_t mem_req_o,
  input  soc_pkg::wb_rsp_t mem_rsp_i,
  output logic             rst_o
);
  import soc_pkg::*;

  logic    sys_rst;
  wb_rsp_t sw_rsp;    // Switch response before the vector mux
  wb_req_t gpio_req;
  wb_rsp_t gpio_rsp;
  iid_t    iid;

  rst_debounce #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) u_rst_debounce (
    .clk     (clk),
    .rst_lck (rst_lck),
    .rst_o   (sys_rst)
  );

  bus_switch u_bus_switch (
    .clk        (clk),
    .rst_i      (sys_rst),
    .m_req_i    (m_req_i),
    .m_rsp_o    (sw_rsp),
    .gpio_req_o (gpio_req),
    .gpio_rsp_i (gpio_rsp),
    .mem_req_o  (mem_req_o),
    .mem_rsp_i  (mem_rsp_i)
  );

  gpio_regs u_gpio_regs (
    .clk    (clk),
    .rst_i  (sys_rst),
    .req_i  (gpio_req),
    .sw_i   (sw_i),
    .rsp_o  (gpio_rsp),
    .leds_o (leds_o)
  );

  simple_pic u_simple_pic (
    .clk    (clk),
    .rst_i  (sys_rst),
    .irq_i  (irq_i),
    .inta_i (inta_i),
    .intr_o (intr_o),
    .iid_o  (iid)
  );

  // Vector word replaces read data while the master acknowledges
  always_comb begin
    m_rsp_o.ack = sw_rsp.ack;
    if (inta_i) begin
      m_rsp_o.dat = {IACK_BASE[$bits(data_t)-1:$bits(iid_t)], iid};
    end else begin
      m_rsp_o.dat = sw_rsp.dat;
    end
  end

  assign rst_o = sys_rst;  // Off-chip peripherals share the system reset

endmodule

/* src/simple_pic.sv */
// Simple interrupt controller
// Edge-detects eight request lines and reports the lowest pending one
module simple_pic (
  input  logic           clk,
  input  logic           rst_i,
  input  soc_pkg::irq_t  irq_i,
  input  logic           inta_i,
  output logic           intr_o,
  output soc_pkg::iid_t  iid_o
);
  import soc_pkg::*;

  irq_t irq_q;
  irq_t rise;
  irq_t clr;
  irq_t pend_q;
  irq_t pend_nxt;
  logic inta_q;
  logic inta_end;
  logic intr_q;
  iid_t iid_q;

  // Lowest line number wins
  function automatic iid_t lowest(input irq_t req);
    iid_t id;
    id = '0;
    for (int i = $bits(irq_t) - 1; i >= 0; i--) begin
      if (req[i]) begin
        id = iid_t'(i);
      end
    end
    return id;
  endfunction

  assign rise     = irq_i & ~irq_q;
  assign inta_end = inta_q & ~inta_i;  // Falling edge of the acknowledge

  always_comb begin
    clr = '0;
    if (inta_end) begin
      clr[iid_q] = 1'b1;
    end
  end

  assign pend_nxt = (pend_q & ~clr) | rise;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      irq_q  <= '0;
      inta_q <= 1'b0;
      pend_q <= '0;
      intr_q <= 1'b0;
      iid_q  <= '0;
    end else begin
      irq_q  <= irq_i;
      inta_q <= inta_i;
      pend_q <= pend_nxt;
      intr_q <= |pend_q;
      if (!inta_i) begin
        iid_q <= lowest(pend_nxt);  // Frozen during the acknowledge
      end
    end
  end

  assign intr_o = intr_q;
  assign iid_o  = iid_q;

endmodule

/* src/gpio_regs.sv */
// GPIO registers
// Switch read register and byte-lane writable LED register on the system bus
module gpio_regs (
  input  logic             clk,
  input  logic             rst_i,
  input  soc_pkg::wb_req_t req_i,
  input  soc_pkg::sw_t     sw_i,
  output soc_pkg::wb_rsp_t rsp_o,
  output soc_pkg::leds_t   leds_o
);
  import soc_pkg::*;

  logic  stb;
  logic  led_sel;
  logic  ack_q;
  data_t rd_q;
  leds_t leds_q;

  assign stb     = req_i.cyc & req_i.stb & ~ack_q;  // Strobe not yet answered
  assign led_sel = req_i.adr[1];                     // Word 0xf102

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= stb;
    end
  end

  // LED writes per byte lane
  always_ff @(posedge clk) begin
    if (rst_i) begin
      leds_q <= '0;
    end else if (stb && req_i.we && led_sel) begin
      if (req_i.sel[0]) begin
        leds_q[7:0] <= req_i.dat[7:0];
      end
      if (req_i.sel[1]) begin
        leds_q[13:8] <= req_i.dat[13:8];  // Upper lane is 6 bits wide
      end
    end
  end

  always_ff @(posedge clk) begin
    if (stb) begin
      rd_q <= led_sel ? data_t'(leds_q) : data_t'(sw_i);  // Zero-extended
    end
  end

  assign rsp_o  = '{dat: rd_q, ack: ack_q};
  assign leds_o = leds_q;

endmodule

/* src/bus_switch.sv */
// System bus switch
// Decodes the master address, routes the strobe to GPIO, memory or the
// default responder and returns the selected target's data and ack
module bus_switch (
  input  logic             clk,
  input  logic             rst_i,
  input  soc_pkg::wb_req_t m_req_i,
  output soc_pkg::wb_rsp_t m_rsp_o,
  output soc_pkg::wb_req_t gpio_req_o,
  input  soc_pkg::wb_rsp_t gpio_rsp_i,
  output soc_pkg::wb_req_t mem_req_o,
  input  soc_pkg::wb_rsp_t mem_rsp_i
);
  import soc_pkg::*;

  typedef logic [2:0] tgt_t;  // One-hot target select

  localparam int TGT_GPIO = 0;
  localparam int TGT_DEF  = 1;
  localparam int TGT_MEM  = 2;

  logic m_stb;
  logic io_gpio;
  tgt_t dec_tgt;
  tgt_t tgt;
  tgt_t tgt_q;
  logic hold_q;
  logic def_ack;
  logic m_ack;

  assign m_stb = m_req_i.cyc & m_req_i.stb;

  // I/O ports decode on the low 16 address bits only
  assign io_gpio = m_req_i.tga && (m_req_i.adr[15:2] == GPIO_BASE[15:2]);

  // Address map, first match wins
  always_comb begin
    dec_tgt = '0;
    if (io_gpio) begin
      dec_tgt[TGT_GPIO] = 1'b1;
    end else if (m_req_i.tga) begin
      dec_tgt[TGT_DEF] = 1'b1;  // Unmapped I/O
    end else begin
      dec_tgt[TGT_MEM] = 1'b1;  // Whole memory space
    end
  end

  // Route stays fixed until the target acks
  assign tgt = hold_q ? tgt_q : dec_tgt;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      hold_q <= 1'b0;
    end else begin
      hold_q <= m_stb & ~m_ack;  // Access still waiting
    end
  end

  always_ff @(posedge clk) begin
    tgt_q <= tgt;
  end

  // Only the selected target sees cyc and stb
  always_comb begin
    gpio_req_o     = m_req_i;
    gpio_req_o.cyc = m_req_i.cyc & tgt[TGT_GPIO];
    gpio_req_o.stb = m_req_i.stb & tgt[TGT_GPIO];

    mem_req_o      = m_req_i;
    mem_req_o.cyc  = m_req_i.cyc & tgt[TGT_MEM];
    mem_req_o.stb  = m_req_i.stb & tgt[TGT_MEM];
  end

  // Default responder answers in the same cycle
  assign def_ack = m_stb & tgt[TGT_DEF];

  // Read data and ack return path
  always_comb begin
    if (tgt[TGT_GPIO]) begin
      m_rsp_o = gpio_rsp_i;
    end else if (tgt[TGT_MEM]) begin
      m_rsp_o = mem_rsp_i;
    end else begin
      m_rsp_o.dat = DEF_RD_DATA;
      m_rsp_o.ack = def_ack;
    end
  end

  assign m_ack = m_rsp_o.ack;

endmodule

/* src/rst_debounce.sv */
// Reset debouncer
// Holds the system reset for a counted time after the board reset is released
module rst_debounce #(
  parameter int DEBOUNCE_CYCLES = 1000
) (
  input  logic clk,
  input  logic rst_lck,
  output logic rst_o
);

  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

  typedef logic [CNT_W-1:0] cnt_t;

  cnt_t cnt_q;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      cnt_q <= cnt_t'(DEBOUNCE_CYCLES);  // Reload on every board reset glitch
      rst_o <= 1'b1;
    end else begin
      if (cnt_q != '0) begin
        cnt_q <= cnt_q - cnt_t'(1);
      end
      rst_o <= (cnt_q != '0);  // Released one cycle after the count runs out
    end
  end

endmodule

/* src/soc_pkg.sv */
// SoC bus fabric shared definitions
// Bus widths, request and response structs and the I/O address map
package soc_pkg;

  typedef logic [19:1] addr_t;  // Word address, byte lane from sel
  typedef logic [15:0] data_t;
  typedef logic [1:0]  sel_t;
  typedef logic [7:0]  irq_t;
  typedef logic [2:0]  iid_t;
  typedef logic [13:0] leds_t;
  typedef logic [9:0]  sw_t;

  // Master request, held steady until ack
  typedef struct packed {
    addr_t adr;
    logic  tga;  // High for I/O space
    data_t dat;
    sel_t  sel;
    logic  we;
    logic  cyc;
    logic  stb;
  } wb_req_t;

  // Target response
  typedef struct packed {
    data_t dat;
    logic  ack;
  } wb_rsp_t;

  // GPIO window at I/O 0xf100 to 0xf103
  // Switches at word 0xf100, LEDs at word 0xf102
  localparam addr_t GPIO_BASE = 19'h07880;

  // Vector word base, iid goes into the low bits
  localparam data_t IACK_BASE = 16'h0008;

  // Unmapped I/O reads float high
  localparam data_t DEF_RD_DATA = 16'hffff;

endpackage
